// File: lane_cfg_pkg.sv
package lane_cfg_pkg;

    ////////////////////
    // Register files
    ////////////////////

    localparam int VREG_DEPTH  = 64;
    localparam int VREG_ADDR_W = $clog2(VREG_DEPTH);
    localparam int MASK_DEPTH  = 32;
    localparam int MASK_ADDR_W = $clog2(MASK_DEPTH);

    ////////////////////
    // Datapath widths
    ////////////////////

    localparam int DATA_W     = 32;
    localparam int BYTES_W    = DATA_W / 8;
    localparam int IMM_W      = 5;
    // Byte position inside a word
    localparam int ELEM_IDX_W = $clog2(BYTES_W);
    // Shift amount taken from the second operand
    localparam int SHAMT_W    = $clog2(DATA_W);

    ////////////////////
    // Pipeline latencies
    ////////////////////

    localparam int FETCH_LAT = 2;
    localparam int EXEC_LAT  = 1;
    // Issue to result_o in cycles
    localparam int LANE_LAT  = FETCH_LAT + EXEC_LAT;

    // Element width
    typedef enum logic [1 : 0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

endpackage

// File: lane_op_pkg.sv
package lane_op_pkg;
    import lane_cfg_pkg::*;

    typedef enum logic [3 : 0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_MSEQ  = 4'd7,
        OP_MSLTU = 4'd8
    } alu_op_e;

    typedef enum logic [1 : 0] {
        SRC_VREG = 2'd0,
        SRC_XREG = 2'd1,
        SRC_IMM  = 2'd2
    } op2_src_e;

    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LOAD = 1'b1
    } wb_src_e;

    ////////////////////
    // Issue bundle
    ////////////////////

    typedef struct packed {
        logic                       valid;
        logic [VREG_ADDR_W - 1 : 0] raddr_a;
        logic [VREG_ADDR_W - 1 : 0] raddr_b;
        logic [ELEM_IDX_W - 1 : 0]  elem_idx;
        sew_e                       sew;
        alu_op_e                    op;
        op2_src_e                   op2_src;
        logic [DATA_W - 1 : 0]      x_val;
        logic [IMM_W - 1 : 0]       imm;
        wb_src_e                    wb_src;
        logic [VREG_ADDR_W - 1 : 0] waddr;
        logic [BYTES_W - 1 : 0]     be;
        logic                       we;
        logic                       vm;
        logic [MASK_ADDR_W - 1 : 0] mask_addr;
        logic                       mask_we;
    } issue_t;

    // Control left over once the reads are sent to the VRF
    typedef struct packed {
        logic                       valid;
        alu_op_e                    op;
        op2_src_e                   op2_src;
        logic [DATA_W - 1 : 0]      x_val;
        logic [IMM_W - 1 : 0]       imm;
        wb_src_e                    wb_src;
        logic [VREG_ADDR_W - 1 : 0] waddr;
        logic [BYTES_W - 1 : 0]     be;
        logic                       we;
        logic                       vm;
        logic [MASK_ADDR_W - 1 : 0] mask_addr;
        logic                       mask_we;
    } exec_ctrl_t;

    typedef struct packed {
        logic [DATA_W - 1 : 0] a;
        logic [DATA_W - 1 : 0] b;
    } operands_t;

    typedef struct packed {
        logic                       we;
        logic [VREG_ADDR_W - 1 : 0] addr;
        logic [BYTES_W - 1 : 0]     be;
        logic [DATA_W - 1 : 0]      data;
    } vrf_wr_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_W - 1 : 0] data;
        logic                  mask;
    } lane_result_t;

endpackage

// File: lane_vrf.sv
module lane_vrf
    import lane_cfg_pkg::*;
    import lane_op_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [VREG_ADDR_W - 1 : 0] raddr_a_i,
    input  logic [VREG_ADDR_W - 1 : 0] raddr_b_i,
    output logic [DATA_W - 1 : 0]      rdata_a_o,
    output logic [DATA_W - 1 : 0]      rdata_b_o,
    input  vrf_wr_t                    wr_i
);

    logic [DATA_W - 1 : 0] mem [VREG_DEPTH];

    // Word seen by a read port, bytes written at this edge merged in
    function automatic logic [DATA_W - 1 : 0] read_word(
        input logic [VREG_ADDR_W - 1 : 0] addr
    );
        logic [DATA_W - 1 : 0] word;
        word = mem[addr];
        for (int b = 0; b < BYTES_W; b++) begin
            if (wr_i.we && wr_i.be[b] && (wr_i.addr == addr)) begin
                word[b * 8 +: 8] = wr_i.data[b * 8 +: 8];
            end
        end
        return word;
    endfunction

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < VREG_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int b = 0; b < BYTES_W; b++) begin
                if (wr_i.we && wr_i.be[b]) begin
                    mem[wr_i.addr][b * 8 +: 8] <= wr_i.data[b * 8 +: 8];
                end
            end
        end
    end

    ////////////////////
    // Read ports
    ////////////////////

    always_ff @(posedge clk_i) begin
        rdata_a_o <= read_word(raddr_a_i);
        rdata_b_o <= read_word(raddr_b_i);
    end

endmodule

// File: lane_operand_fetch.sv
module lane_operand_fetch
    import lane_cfg_pkg::*;
    import lane_op_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [VREG_ADDR_W - 1 : 0] raddr_a_i,
    input  logic [VREG_ADDR_W - 1 : 0] raddr_b_i,
    input  logic [ELEM_IDX_W - 1 : 0]  elem_idx_i,
    input  sew_e                       sew_i,
    input  vrf_wr_t                    wr_i,
    output operands_t                  operands_o
);

    logic [DATA_W - 1 : 0]     rdata_a;
    logic [DATA_W - 1 : 0]     rdata_b;
    logic [ELEM_IDX_W - 1 : 0] elem_idx_q;
    sew_e                      sew_q;

    // Pick one element of a word and zero-extend it
    function automatic logic [DATA_W - 1 : 0] extract(
        input logic [DATA_W - 1 : 0]     word,
        input logic [ELEM_IDX_W - 1 : 0] idx,
        input sew_e                      sew
    );
        logic [DATA_W - 1 : 0] elem;
        elem = '0;
        case (sew)
            SEW_8:   elem[7 : 0] = word[idx * 8 +: 8];
            // Halfword chosen by the low index bit
            SEW_16:  elem[15 : 0] = word[idx[0] * 16 +: 16];
            SEW_32:  elem = word;
            default: elem = '0;
        endcase
        return elem;
    endfunction

    lane_vrf u_vrf (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .raddr_a_i (raddr_a_i),
        .raddr_b_i (raddr_b_i),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b),
        .wr_i      (wr_i)
    );

    // Index and width wait one cycle for the read data
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            elem_idx_q <= '0;
            sew_q      <= SEW_32;
        end else begin
            elem_idx_q <= elem_idx_i;
            sew_q      <= sew_i;
        end
    end

    ////////////////////
    // Element extractor
    ////////////////////

    always_ff @(posedge clk_i) begin
        operands_o.a <= extract(rdata_a, elem_idx_q, sew_q);
        operands_o.b <= extract(rdata_b, elem_idx_q, sew_q);
    end

endmodule

// File: lane_ctrl_delay.sv
module lane_ctrl_delay
    import lane_cfg_pkg::*;
    import lane_op_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  issue_t     issue_i,
    output exec_ctrl_t ctrl_o
);

    exec_ctrl_t ctrl_in;
    exec_ctrl_t line_q [FETCH_LAT];

    // Fields the execute stage needs
    always_comb begin
        ctrl_in.valid     = issue_i.valid;
        ctrl_in.op        = issue_i.op;
        ctrl_in.op2_src   = issue_i.op2_src;
        ctrl_in.x_val     = issue_i.x_val;
        ctrl_in.imm       = issue_i.imm;
        ctrl_in.wb_src    = issue_i.wb_src;
        ctrl_in.waddr     = issue_i.waddr;
        ctrl_in.be        = issue_i.be;
        ctrl_in.we        = issue_i.we;
        ctrl_in.vm        = issue_i.vm;
        ctrl_in.mask_addr = issue_i.mask_addr;
        ctrl_in.mask_we   = issue_i.mask_we;
    end

    // Same depth as the operand fetch path
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int i = 0; i < FETCH_LAT; i++) begin
                line_q[i].valid   <= 1'b0;
                line_q[i].we      <= 1'b0;
                line_q[i].mask_we <= 1'b0;
            end
        end else begin
            line_q[0] <= ctrl_in;
            for (int i = 1; i < FETCH_LAT; i++) begin
                line_q[i] <= line_q[i - 1];
            end
        end
    end

    assign ctrl_o = line_q[FETCH_LAT - 1];

endmodule

// File: lane_execute.sv
module lane_execute
    import lane_cfg_pkg::*;
    import lane_op_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  operands_t             operands_i,
    input  exec_ctrl_t            ctrl_i,
    input  logic [DATA_W - 1 : 0] load_data_i,
    output vrf_wr_t               vrf_wr_o,
    output lane_result_t          result_o
);

    logic [DATA_W - 1 : 0]      op_b;
    logic [DATA_W - 1 : 0]      alu_data;
    logic                       cmp_bit;
    logic [DATA_W - 1 : 0]      wb_data;
    logic [BYTES_W - 1 : 0]     wb_be;
    logic                       mask_bit;

    // Mask register file and its pending write
    logic [MASK_DEPTH - 1 : 0]  vmrf;
    logic                       vmrf_we_q;
    logic [MASK_ADDR_W - 1 : 0] vmrf_addr_q;
    logic                       vmrf_bit_q;

    ////////////////////
    // Second operand
    ////////////////////

    always_comb begin
        case (ctrl_i.op2_src)
            SRC_VREG: op_b = operands_i.b;
            SRC_XREG: op_b = ctrl_i.x_val;
            SRC_IMM:  op_b = {{(DATA_W - IMM_W){1'b0}}, ctrl_i.imm};
            default:  op_b = operands_i.b;
        endcase
    end

    ////////////////////
    // ALU
    ////////////////////

    always_comb begin
        cmp_bit  = 1'b0;
        alu_data = '0;
        case (ctrl_i.op)
            OP_ADD: alu_data = operands_i.a + op_b;
            OP_SUB: alu_data = operands_i.a - op_b;
            OP_AND: alu_data = operands_i.a & op_b;
            OP_OR:  alu_data = operands_i.a | op_b;
            OP_XOR: alu_data = operands_i.a ^ op_b;
            OP_SLL: alu_data = operands_i.a << op_b[SHAMT_W - 1 : 0];
            OP_SRL: alu_data = operands_i.a >> op_b[SHAMT_W - 1 : 0];
            OP_MSEQ: begin
                cmp_bit  = (operands_i.a == op_b);
                alu_data = {{(DATA_W - 1){1'b0}}, cmp_bit};
            end
            OP_MSLTU: begin
                cmp_bit  = (operands_i.a < op_b);
                alu_data = {{(DATA_W - 1){1'b0}}, cmp_bit};
            end
            default: alu_data = '0;
        endcase
    end

    ////////////////////
    // Write-back select
    ////////////////////

    assign mask_bit = vmrf[ctrl_i.mask_addr];

    always_comb begin
        wb_data = (ctrl_i.wb_src == WB_LOAD) ? load_data_i : alu_data;
        wb_be   = ctrl_i.be;
        // Masked-off element keeps its old value
        if (ctrl_i.vm && !mask_bit) begin
            wb_be = '0;
        end
    end

    // Result, VRF write and mask write register together
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            vrf_wr_o.we    <= 1'b0;
            result_o.valid <= 1'b0;
            vmrf_we_q      <= 1'b0;
        end else begin
            vrf_wr_o.we    <= ctrl_i.valid && ctrl_i.we;
            result_o.valid <= ctrl_i.valid;
            vmrf_we_q      <= ctrl_i.valid && ctrl_i.mask_we;
        end
        vrf_wr_o.addr <= ctrl_i.waddr;
        vrf_wr_o.be   <= wb_be;
        vrf_wr_o.data <= wb_data;
        result_o.data <= alu_data;
        result_o.mask <= cmp_bit;
        vmrf_addr_q   <= ctrl_i.mask_addr;
        vmrf_bit_q    <= cmp_bit;
    end

    // Mask bit lands on the same edge as the VRF write
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            vmrf <= '0;
        end else if (vmrf_we_q) begin
            vmrf[vmrf_addr_q] <= vmrf_bit_q;
        end
    end

endmodule

// File: vector_lane.sv
module vector_lane
    import lane_cfg_pkg::*;
    import lane_op_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  issue_t                issue_i,
    input  logic [DATA_W - 1 : 0] load_data_i,
    output lane_result_t          result_o
);

    operands_t  operands;
    exec_ctrl_t exec_ctrl;
    vrf_wr_t    vrf_wr;

    // Register reads and element extraction
    lane_operand_fetch u_fetch (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .raddr_a_i  (issue_i.raddr_a),
        .raddr_b_i  (issue_i.raddr_b),
        .elem_idx_i (issue_i.elem_idx),
        .sew_i      (issue_i.sew),
        .wr_i       (vrf_wr),
        .operands_o (operands)
    );

    // Control runs beside the operands
    lane_ctrl_delay u_ctrl (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .issue_i (issue_i),
        .ctrl_o  (exec_ctrl)
    );

    lane_execute u_exec (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .operands_i  (operands),
        .ctrl_i      (exec_ctrl),
        .load_data_i (load_data_i),
        .vrf_wr_o    (vrf_wr),
        .result_o    (result_o)
    );

endmodule

// File: vector_lane_asserts.sv
module vector_lane_asserts
    import lane_cfg_pkg::*;
    import lane_op_pkg::*;
(
    input logic         clk_i,
    input logic         rst_i,
    input issue_t       issue_i,
    input lane_result_t result_o
);

    ////////////////////
    // Reset
    ////////////////////

    a_reset_no_valid: assert property (
        @(posedge clk_i) !rst_i |=> !result_o.valid
    ) else $error("result valid high after a reset cycle");

    ////////////////////
    // Latency
    ////////////////////

    a_issue_to_result: assert property (
        @(posedge clk_i) disable iff (!rst_i) issue_i.valid |-> ##LANE_LAT result_o.valid
    ) else $error("issue not followed by a result");

    a_result_from_issue: assert property (
        @(posedge clk_i) disable iff (!rst_i) result_o.valid |-> $past(issue_i.valid, LANE_LAT)
    ) else $error("result without a matching issue");

    // Element width must be one of the three encodings
    a_sew_legal: assert property (
        @(posedge clk_i) disable iff (!rst_i)
            issue_i.valid |-> (issue_i.sew inside {SEW_8, SEW_16, SEW_32})
    ) else $error("illegal sew on a valid issue");

endmodule

bind vector_lane vector_lane_asserts u_asserts (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .issue_i  (issue_i),
    .result_o (result_o)
);

// File: tb_vector_lane.sv
module tb_vector_lane
    import lane_cfg_pkg::*;
    import lane_op_pkg::*;
;

    localparam int NUM_TESTS       = 6;
    // About 60 operations of up to 8 cycles each on top of 40 cycles per test
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 500;
    localparam int RESULT_WAIT     = 8;

    logic                  clk_i;
    logic                  rst_i;
    issue_t                issue_i;
    logic [DATA_W - 1 : 0] load_data_i;
    lane_result_t          result_o;

    // Reference state
    logic [DATA_W - 1 : 0] vreg [VREG_DEPTH];
    logic                  vmask [MASK_DEPTH];
    logic [31 : 0]         lcg_state = 32'd81571;
    int                    value_errors = 0;
    int                    missing_errors = 0;

    vector_lane DUT (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .issue_i     (issue_i),
        .load_data_i (load_data_i),
        .result_o    (result_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    function automatic logic [31 : 0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic issue_t idle_issue();
        issue_t iss;
        iss = '0;
        iss.sew = SEW_32;
        iss.op = OP_ADD;
        iss.op2_src = SRC_IMM;
        iss.wb_src = WB_ALU;
        return iss;
    endfunction

    // Plain read of a register element as a + 0
    function automatic issue_t read_issue(logic [VREG_ADDR_W - 1 : 0] ra, sew_e sew,
                                          logic [ELEM_IDX_W - 1 : 0] idx);
        issue_t iss;
        iss = idle_issue();
        iss.raddr_a = ra;
        iss.sew = sew;
        iss.elem_idx = idx;
        return iss;
    endfunction

    function automatic issue_t load_issue(logic [VREG_ADDR_W - 1 : 0] wa,
                                          logic [BYTES_W - 1 : 0] be);
        issue_t iss;
        iss = idle_issue();
        iss.wb_src = WB_LOAD;
        iss.waddr = wa;
        iss.be = be;
        iss.we = 1'b1;
        return iss;
    endfunction

    function automatic logic [31 : 0] elem_of(logic [31 : 0] word, logic [1 : 0] idx, sew_e sew);
        case (sew)
            SEW_8:   return (word >> (8 * idx)) & 32'h0000_00ff;
            SEW_16:  return idx[0] ? (word >> 16) : (word & 32'h0000_ffff);
            default: return word;
        endcase
    endfunction

    function automatic logic [31 : 0] model_alu(alu_op_e op, logic [31 : 0] a, logic [31 : 0] b);
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLL:   return a << b[4 : 0];
            OP_SRL:   return a >> b[4 : 0];
            OP_MSEQ:  return (a == b) ? 32'd1 : 32'd0;
            OP_MSLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_result(input lane_result_t got, input lane_result_t exp, input string tag);
        if (got.data !== exp.data) begin
            value_errors++;
            $display("[FAIL] t=%0t %s: data %h, expected %h", $time, tag, got.data, exp.data);
        end
    endtask

    task automatic check_mask(input logic got, input logic exp, input string tag);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] t=%0t %s: mask bit %b, expected %b", $time, tag, got, exp);
        end
    endtask

    task automatic wait_result(output lane_result_t got, output bit found);
        found = 1'b0;
        got = '0;
        for (int i = 0; i < RESULT_WAIT; i++) begin
            @(negedge clk_i);
            if (result_o.valid) begin
                got = result_o;
                found = 1'b1;
                break;
            end
        end
    endtask

    // One issue checked against the model before the model is updated
    task automatic exec_op(input issue_t iss, input logic [31 : 0] ld, input string tag);
        logic [31 : 0] a;
        logic [31 : 0] b;
        logic [31 : 0] wdata;
        logic [3 : 0]  be;
        lane_result_t  exp;
        lane_result_t  got;
        bit            found;
        iss.valid = 1'b1;
        a = elem_of(vreg[iss.raddr_a], iss.elem_idx, iss.sew);
        case (iss.op2_src)
            SRC_XREG: b = iss.x_val;
            SRC_IMM:  b = {27'd0, iss.imm};
            default:  b = elem_of(vreg[iss.raddr_b], iss.elem_idx, iss.sew);
        endcase
        exp.valid = 1'b1;
        exp.data = model_alu(iss.op, a, b);
        exp.mask = (iss.op == OP_MSEQ || iss.op == OP_MSLTU) ? exp.data[0] : 1'b0;
        @(posedge clk_i);
        issue_i <= iss;
        load_data_i <= ld;
        @(posedge clk_i);
        issue_i <= idle_issue();
        wait_result(got, found);
        if (!found) begin
            missing_errors++;
            $display("No result valid seen for %s at t=%0t", tag, $time);
        end else begin
            check_result(got, exp, tag);
            check_mask(got.mask, exp.mask, tag);
        end
        be = iss.be;
        if (iss.vm && !vmask[iss.mask_addr]) begin
            be = 4'b0000;
        end
        wdata = (iss.wb_src == WB_LOAD) ? ld : exp.data;
        if (iss.we) begin
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    vreg[iss.waddr][k * 8 +: 8] = wdata[k * 8 +: 8];
                end
            end
        end
        if (iss.mask_we) begin
            vmask[iss.mask_addr] = exp.mask;
        end
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic test_load_readback();
        for (int r = 0; r < 8; r++) begin
            exec_op(load_issue(r[5 : 0], 4'hf), lcg_next(), "load");
        end
        for (int r = 0; r < 8; r++) begin
            exec_op(read_issue(r[5 : 0], SEW_32, 2'd0), 32'd0, "readback");
        end
    endtask

    task automatic test_alu_ops();
        alu_op_e    ops [7];
        op2_src_e   srcs [3];
        issue_t     iss;
        logic [31 : 0] r;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};
        srcs = '{SRC_VREG, SRC_XREG, SRC_IMM};
        foreach (ops[o]) begin
            foreach (srcs[s]) begin
                r = lcg_next();
                iss = read_issue({3'd0, r[2 : 0]}, SEW_32, 2'd0);
                iss.raddr_b = {3'd0, r[5 : 3]};
                iss.imm = r[12 : 8];
                iss.op = ops[o];
                iss.op2_src = srcs[s];
                iss.x_val = lcg_next();
                exec_op(iss, 32'd0, "alu");
            end
        end
    endtask

    task automatic test_extract();
        exec_op(load_issue(6'd10, 4'hf), 32'ha1b2_c3d4, "extract load");
        for (int i = 0; i < 4; i++) begin
            exec_op(read_issue(6'd10, SEW_8, i[1 : 0]), 32'd0, "sew8");
        end
        exec_op(read_issue(6'd10, SEW_16, 2'd0), 32'd0, "sew16 low");
        exec_op(read_issue(6'd10, SEW_16, 2'd1), 32'd0, "sew16 high");
    endtask

    task automatic test_byte_enables();
        exec_op(load_issue(6'd11, 4'hf), 32'h1122_3344, "be init");
        exec_op(load_issue(6'd11, 4'b0101), 32'haabb_ccdd, "be 0101");
        exec_op(read_issue(6'd11, SEW_32, 2'd0), 32'd0, "be read 1");
        exec_op(load_issue(6'd11, 4'b1000), 32'h5566_7788, "be 1000");
        exec_op(read_issue(6'd11, SEW_32, 2'd0), 32'd0, "be read 2");
    endtask

    task automatic test_mask();
        issue_t iss;
        // Register 10 compared with itself sets bit 3
        iss = read_issue(6'd10, SEW_32, 2'd0);
        iss.raddr_b = 6'd10;
        iss.op = OP_MSEQ;
        iss.op2_src = SRC_VREG;
        iss.mask_we = 1'b1;
        iss.mask_addr = 5'd3;
        exec_op(iss, 32'd0, "mseq set");
        iss.op2_src = SRC_XREG;
        iss.x_val = 32'd0;
        iss.mask_addr = 5'd4;
        exec_op(iss, 32'd0, "mseq clear");
        iss.op = OP_MSLTU;
        iss.x_val = 32'hffff_ffff;
        iss.mask_addr = 5'd5;
        exec_op(iss, 32'd0, "msltu");
        exec_op(load_issue(6'd12, 4'hf), 32'h0bad_f00d, "mask init");
        iss = load_issue(6'd12, 4'hf);
        iss.vm = 1'b1;
        iss.mask_addr = 5'd4;
        exec_op(iss, 32'hdead_beef, "masked off");
        exec_op(read_issue(6'd12, SEW_32, 2'd0), 32'd0, "masked off read");
        iss.mask_addr = 5'd3;
        exec_op(iss, 32'hcafe_0001, "masked on");
        exec_op(read_issue(6'd12, SEW_32, 2'd0), 32'd0, "masked on read");
    endtask

    task automatic test_back_to_back();
        issue_t       iss [3];
        lane_result_t exp [3];
        lane_result_t got;
        bit           found;
        for (int i = 0; i < 3; i++) begin
            iss[i] = read_issue(i[5 : 0], SEW_32, 2'd0);
            iss[i].valid = 1'b1;
            iss[i].op = OP_XOR;
            iss[i].op2_src = SRC_XREG;
            iss[i].x_val = lcg_next();
            exp[i].valid = 1'b1;
            exp[i].data = vreg[i] ^ iss[i].x_val;
            exp[i].mask = 1'b0;
        end
        for (int i = 0; i < 3; i++) begin
            @(posedge clk_i);
            issue_i <= iss[i];
        end
        @(posedge clk_i);
        issue_i <= idle_issue();
        wait_result(got, found);
        if (!found) begin
            missing_errors++;
            $display("No result valid seen for the back-to-back burst at t=%0t", $time);
        end else begin
            check_result(got, exp[0], "burst 0");
            check_mask(got.mask, exp[0].mask, "burst 0");
            for (int i = 1; i < 3; i++) begin
                @(negedge clk_i);
                if (!result_o.valid) begin
                    missing_errors++;
                    $display("Burst result %0d not valid on its cycle at t=%0t", i, $time);
                end else begin
                    check_result(result_o, exp[i], "burst");
                    check_mask(result_o.mask, exp[i].mask, "burst");
                end
            end
        end
    endtask

    initial begin
        rst_i = 1'b0;
        issue_i = idle_issue();
        load_data_i = '0;
        for (int i = 0; i < VREG_DEPTH; i++) begin
            vreg[i] = '0;
        end
        for (int i = 0; i < MASK_DEPTH; i++) begin
            vmask[i] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b1;
        test_load_readback();
        test_alu_ops();
        test_extract();
        test_byte_enables();
        test_mask();
        test_back_to_back();
        repeat (4) @(posedge clk_i);
        $display("Errors: %0d wrong values, %0d missing results", value_errors, missing_errors);
        if (value_errors + missing_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: filelist.f
lane_cfg_pkg.sv
lane_op_pkg.sv
lane_vrf.sv
lane_operand_fetch.sv
lane_ctrl_delay.sv
lane_execute.sv
vector_lane.sv
vector_lane_asserts.sv
tb_vector_lane.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_vector_lane
RTL_TOP   ?= vector_lane
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^=== PASS ===$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
